//--- hdl/fetch_pkg.sv
// Shared widths, PC select codes and fetch state for the RV32 fetch stage
package fetch_pkg;

  localparam int ADDR_W   = 32;
  localparam int INST_W   = 32;
  localparam int PC_SEL_W = 3;

  // Byte address or PC value
  typedef logic [ADDR_W-1:0] addr_t;
  // Raw instruction word
  typedef logic [INST_W-1:0] inst_t;
  // Next PC source, codes 5 to 7 fall back to sequential
  typedef logic [PC_SEL_W-1:0] pc_sel_t;

  localparam pc_sel_t PC_SEL_SEQ  = 3'd0;
  localparam pc_sel_t PC_SEL_JREG = 3'd1;
  localparam pc_sel_t PC_SEL_BR   = 3'd2;
  localparam pc_sel_t PC_SEL_JMP  = 3'd3;
  localparam pc_sel_t PC_SEL_TRAP = 3'd4;

  // One instruction is one 32-bit word
  localparam addr_t PC_STEP = 32'd4;

  // Fixed trap entry point
  localparam addr_t TRAP_VECTOR = 32'h0000_0100;

  // ebreak stops the core
  localparam inst_t EBREAK_INST = 32'h0010_0073;

  typedef enum logic [1:0] {
    IDLE,
    FETCH_REQ,
    FETCH_WAIT,
    FETCH_DONE
  } fetch_state_t;

endpackage

//--- hdl/axil_read_if.sv
// AXI4-Lite read address and read data channels between fetch and memory
`timescale 1ns/100ps

interface axil_read_if
  import fetch_pkg::*;
();

  // Read address channel
  logic  arvalid;
  logic  arready;
  addr_t araddr;

  // Read data channel
  logic  rvalid;
  logic  rready;
  inst_t rdata;

  modport manager (
    output arvalid, araddr, rready,
    input  arready, rvalid, rdata
  );

  modport subordinate (
    input  arvalid, araddr, rready,
    output arready, rvalid, rdata
  );

endinterface

//--- hdl/inst_fetch.sv
// Fetch unit with PC select, AXI4-Lite instruction read and ebreak halt detection
`timescale 1ns/100ps

module inst_fetch
  import fetch_pkg::*;
#(
  parameter addr_t RESET_PC = '0
) (
  input  logic    clk,
  input  logic    rst,
  // Redirect information from the later stages
  input  pc_sel_t pc_sel,
  input  addr_t   jump_reg_target,
  input  addr_t   br_target,
  input  addr_t   jmp_target,
  input  logic    pc_wen,
  // Decode handshake
  output addr_t   pc,
  output inst_t   inst,
  output logic    inst_valid,
  input  logic    inst_ready,
  output logic    halt,
  // Instruction memory read channel
  axil_read_if.manager mem
);

  fetch_state_t state;
  addr_t        pc_q;
  addr_t        pc_next;
  addr_t        pc_plus_step;
  inst_t        inst_buf;
  logic         arvalid_q;
  logic         rready_q;
  logic         inst_valid_q;
  logic         halt_q;

  logic ar_hs;
  logic r_hs;
  logic dec_hs;
  logic pc_load;

  assign ar_hs   = mem.arvalid && mem.arready;
  assign r_hs    = mem.rvalid && mem.rready;
  assign dec_hs  = inst_valid_q && inst_ready;
  // A new PC is only taken while waiting for the next request
  assign pc_load = (state == IDLE) && pc_wen;

  // Next PC mux
  assign pc_plus_step = pc_q + PC_STEP;

  always_comb begin
    case (pc_sel)
      PC_SEL_JREG: pc_next = jump_reg_target;
      PC_SEL_BR:   pc_next = br_target;
      PC_SEL_JMP:  pc_next = jmp_target;
      PC_SEL_TRAP: pc_next = TRAP_VECTOR;
      default:     pc_next = pc_plus_step;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc_q <= RESET_PC;
    end else if (pc_load) begin
      pc_q <= pc_next;
    end
  end

  // Fetch FSM, outputs are registered so arvalid follows the state by one cycle
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state        <= FETCH_REQ;
      arvalid_q    <= 1'b0;
      rready_q     <= 1'b0;
      inst_valid_q <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (pc_wen) begin
            state <= FETCH_REQ;
          end
        end

        FETCH_REQ: begin
          if (ar_hs) begin
            arvalid_q <= 1'b0;
            rready_q  <= 1'b1;
            state     <= FETCH_WAIT;
          end else begin
            arvalid_q <= 1'b1;
          end
        end

        FETCH_WAIT: begin
          if (r_hs) begin
            rready_q     <= 1'b0;
            inst_valid_q <= 1'b1;
            state        <= FETCH_DONE;
          end
        end

        FETCH_DONE: begin
          // Hold the word under back-pressure
          if (dec_hs) begin
            inst_valid_q <= 1'b0;
            state        <= IDLE;
          end
        end

        default: begin
          state        <= IDLE;
          arvalid_q    <= 1'b0;
          rready_q     <= 1'b0;
          inst_valid_q <= 1'b0;
        end
      endcase
    end
  end

  // Instruction buffer
  always_ff @(posedge clk) begin
    if ((state == FETCH_WAIT) && r_hs) begin
      inst_buf <= mem.rdata;
    end
  end

  // Sticky halt once ebreak has been presented to decode
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      halt_q <= 1'b0;
    end else if (inst_valid_q && (inst_buf == EBREAK_INST)) begin
      halt_q <= 1'b1;
    end
  end

  assign mem.arvalid = arvalid_q;
  assign mem.araddr  = pc_q;
  assign mem.rready  = rready_q;

  assign pc         = pc_q;
  assign inst       = inst_buf;
  assign inst_valid = inst_valid_q;
  assign halt       = halt_q;

endmodule

//--- hdl/imem_axil.sv
// Instruction SRAM with a load port and a fixed-latency AXI4-Lite read port
`timescale 1ns/100ps

module imem_axil
  import fetch_pkg::*;
#(
  parameter int IMEM_DEPTH  = 256,
  parameter int MEM_LATENCY = 2
) (
  input  logic  clk,
  input  logic  rst,
  // Program load
  input  logic  load_en,
  input  addr_t load_addr,
  input  inst_t load_data,
  // Read port
  axil_read_if.subordinate bus
);

  localparam int IDX_W = (IMEM_DEPTH > 1) ? $clog2(IMEM_DEPTH) : 1;
  localparam int CNT_W = (MEM_LATENCY > 1) ? $clog2(MEM_LATENCY) : 1;

  typedef logic [IDX_W-1:0] idx_t;
  typedef logic [CNT_W-1:0] cnt_t;

  inst_t ram [IMEM_DEPTH];

  idx_t  load_idx;
  idx_t  rd_idx;
  cnt_t  lat_cnt;
  logic  busy;
  logic  rvalid_q;
  inst_t rdata_q;

  logic ar_hs;
  logic r_hs;
  logic lat_done;

  // Byte address to word index, wrapping at the array size
  assign load_idx = load_addr[IDX_W+1:2];

  assign ar_hs    = bus.arvalid && bus.arready;
  assign r_hs     = rvalid_q && bus.rready;
  assign lat_done = busy && !rvalid_q && (lat_cnt == '0);

  always_ff @(posedge clk) begin
    if (load_en) begin
      ram[load_idx] <= load_data;
    end
  end

  // Word index of the outstanding read
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      rd_idx <= bus.araddr[IDX_W+1:2];
    end
  end

  // One read in flight at a time
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy     <= 1'b0;
      lat_cnt  <= '0;
      rvalid_q <= 1'b0;
    end else begin
      if (ar_hs) begin
        busy    <= 1'b1;
        lat_cnt <= cnt_t'(MEM_LATENCY - 1);
      end else if (busy && !rvalid_q && (lat_cnt != '0)) begin
        lat_cnt <= lat_cnt - 1'b1;
      end

      if (lat_done) begin
        rvalid_q <= 1'b1;
      end else if (r_hs) begin
        rvalid_q <= 1'b0;
        busy     <= 1'b0;
      end
    end
  end

  // Word is sampled once and held until rready
  always_ff @(posedge clk) begin
    if (lat_done) begin
      rdata_q <= ram[rd_idx];
    end
  end

  assign bus.arready = !busy;
  assign bus.rvalid  = rvalid_q;
  assign bus.rdata   = rdata_q;

endmodule

//--- hdl/inst_fetch_top.sv
// Fetch stage top level joining the fetch unit and instruction memory
`timescale 1ns/100ps

module inst_fetch_top
  import fetch_pkg::*;
#(
  parameter addr_t RESET_PC    = '0,
  parameter int    IMEM_DEPTH  = 256,
  parameter int    MEM_LATENCY = 2
) (
  input  logic    clk,
  input  logic    rst,
  // Redirect inputs
  input  pc_sel_t pc_sel,
  input  addr_t   jump_reg_target,
  input  addr_t   br_target,
  input  addr_t   jmp_target,
  input  logic    pc_wen,
  // Decode handshake
  input  logic    inst_ready,
  output addr_t   pc,
  output inst_t   inst,
  output logic    inst_valid,
  output logic    halt,
  // Program load port
  input  logic    load_en,
  input  addr_t   load_addr,
  input  inst_t   load_data
);

  // Fetch to memory read channel
  axil_read_if axil0 ();

  inst_fetch #(
    .RESET_PC (RESET_PC)
  ) fetch0 (
    .clk             (clk),
    .rst             (rst),
    .pc_sel          (pc_sel),
    .jump_reg_target (jump_reg_target),
    .br_target       (br_target),
    .jmp_target      (jmp_target),
    .pc_wen          (pc_wen),
    .pc              (pc),
    .inst            (inst),
    .inst_valid      (inst_valid),
    .inst_ready      (inst_ready),
    .halt            (halt),
    .mem             (axil0.manager)
  );

  // Memory keeps its contents across reset
  imem_axil #(
    .IMEM_DEPTH  (IMEM_DEPTH),
    .MEM_LATENCY (MEM_LATENCY)
  ) imem0 (
    .clk       (clk),
    .rst       (rst),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .bus       (axil0.subordinate)
  );

endmodule

//--- dv/inst_fetch_checker.sv
// Fetch unit checker for read address and decode handshakes, state and halt
`timescale 1ns/100ps

module inst_fetch_checker
  import fetch_pkg::*;
(
  input logic         clk,
  input logic         rst,
  input fetch_state_t state,
  input logic         arvalid,
  input logic         arready,
  input addr_t        araddr,
  input logic         inst_valid,
  input logic         inst_ready,
  input inst_t        inst,
  input logic         halt
);

  // Read address is held until the memory takes it
  ar_hold: assert property (@(posedge clk) disable iff (rst)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else $error("read address dropped or changed before arready");

  // Decode side keeps the word until inst_ready
  inst_hold: assert property (@(posedge clk) disable iff (rst)
    inst_valid && !inst_ready |=> inst_valid && $stable(inst))
    else $error("instruction dropped or changed before inst_ready");

  valid_only_done: assert property (@(posedge clk) disable iff (rst)
    (state != FETCH_DONE) |-> !inst_valid)
    else $error("inst_valid high outside FETCH_DONE");

  // Sticky until reset
  halt_sticky: assert property (@(posedge clk) disable iff (rst)
    halt |=> halt)
    else $error("halt fell without reset");

endmodule

bind inst_fetch inst_fetch_checker chk0 (
  .clk        (clk),
  .rst        (rst),
  .state      (state),
  .arvalid    (mem.arvalid),
  .arready    (mem.arready),
  .araddr     (mem.araddr),
  .inst_valid (inst_valid),
  .inst_ready (inst_ready),
  .inst       (inst),
  .halt       (halt)
);

//--- dv/inst_fetch_tb.sv
// Testbench for the fetch stage with a PC reference model, memory copy and handshake checks
`timescale 1ns/100ps

module inst_fetch_tb;
  import fetch_pkg::*;

  localparam addr_t RESET_PC      = '0;
  localparam int    IMEM_DEPTH    = 256;
  localparam int    MEM_LATENCY   = 2;
  localparam int    RESET_CYCLES  = 8;
  localparam int    SEQ_FETCHES   = IMEM_DEPTH + 4;
  localparam int    RAND_FETCHES  = 150;
  localparam int    BP_FETCHES    = 60;
  localparam int    NOISE_FETCHES = 60;
  localparam int    HALT_FETCHES  = 5;
  localparam int    TOTAL_FETCHES = 1 + SEQ_FETCHES + RAND_FETCHES + BP_FETCHES
                                    + NOISE_FETCHES + HALT_FETCHES;
  // Per-fetch bound of 20 cycles plus program load and reset
  localparam int    TIMEOUT_CYCLES = TOTAL_FETCHES * 20 + IMEM_DEPTH + RESET_CYCLES;
  localparam addr_t HALT_ADDR     = 32'h0000_02c0;

  logic    clk = 1'b0;
  logic    rst;
  pc_sel_t pc_sel;
  addr_t   jump_reg_target;
  addr_t   br_target;
  addr_t   jmp_target;
  logic    pc_wen;
  logic    inst_ready;
  logic    load_en;
  addr_t   load_addr;
  inst_t   load_data;
  addr_t   pc;
  inst_t   inst;
  logic    inst_valid;
  logic    halt;

  integer  seed = 32'he4342afa;
  inst_t   mem_copy [IMEM_DEPTH];
  addr_t   exp_q [$];
  addr_t   exp_pc;
  addr_t   exp_addr;
  int      delivered = 0;
  logic    held = 1'b0;
  logic    taken = 1'b0;
  addr_t   held_pc;
  inst_t   held_inst;

  inst_fetch_top #(
    .RESET_PC    (RESET_PC),
    .IMEM_DEPTH  (IMEM_DEPTH),
    .MEM_LATENCY (MEM_LATENCY)
  ) dut0 (
    .clk             (clk),
    .rst             (rst),
    .pc_sel          (pc_sel),
    .jump_reg_target (jump_reg_target),
    .br_target       (br_target),
    .jmp_target      (jmp_target),
    .pc_wen          (pc_wen),
    .inst_ready      (inst_ready),
    .pc              (pc),
    .inst            (inst),
    .inst_valid      (inst_valid),
    .halt            (halt),
    .load_en         (load_en),
    .load_addr       (load_addr),
    .load_data       (load_data)
  );

  always #2 clk = ~clk;

  // Next PC by the select rule
  function automatic addr_t next_pc(input addr_t cur, input pc_sel_t sel,
                                    input addr_t jr, input addr_t br, input addr_t jmp);
    case (sel)
      3'd1:    return jr;
      3'd2:    return br;
      3'd3:    return jmp;
      3'd4:    return 32'h0000_0100;
      default: return cur + 32'd4;
    endcase
  endfunction

  function automatic inst_t expected_inst(input addr_t a);
    return mem_copy[(a >> 2) % IMEM_DEPTH];
  endfunction

  task automatic stop_run();
    $display("tests failed");
    $fatal(1, "run stopped after a failure");
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  // Redirect request that the DUT takes on the next edge while idle
  task automatic issue_fetch(input pc_sel_t sel, input addr_t jr, input addr_t br,
                             input addr_t jmp);
    pc_sel          <= sel;
    jump_reg_target <= jr;
    br_target       <= br;
    jmp_target      <= jmp;
    pc_wen          <= 1'b1;
    exp_pc = next_pc(exp_pc, sel, jr, br, jmp);
    exp_q.push_back(exp_pc);
    @(posedge clk);
    pc_wen <= 1'b0;
  endtask

  // Wait for inst_valid, stall, then take the word
  task automatic accept_inst(input int stall, input bit noise);
    do begin
      @(posedge clk);
      if (noise && !inst_valid) begin
        pc_wen <= 1'($random(seed));
        pc_sel <= pc_sel_t'($random(seed));
      end else begin
        pc_wen <= 1'b0;
      end
    end while (!inst_valid);
    repeat (stall) @(posedge clk);
    inst_ready <= 1'b1;
    @(posedge clk);
    inst_ready <= 1'b0;
  endtask

  function automatic addr_t rand_target();
    return addr_t'($random(seed)) & 32'hffff_fffc;
  endfunction

  // Compare at every decode handshake
  always @(posedge clk) begin
    if (rst) begin
      check_value(inst_valid, 1'b0, "inst_valid during reset");
      held = 1'b0;
      taken = 1'b0;
    end else begin
      if (taken)
        check_value(inst_valid, 1'b0, "inst_valid after acceptance");
      if (held) begin
        check_value(inst_valid, 1'b1, "inst_valid under back-pressure");
        check_value(pc, held_pc, "pc under back-pressure");
        check_value(inst, held_inst, "inst under back-pressure");
      end
      taken = 1'b0;
      held = 1'b0;
      if (inst_valid && inst_ready) begin
        if (exp_q.size() == 0) begin
          $display("an instruction was delivered with no fetch outstanding");
          stop_run();
        end
        exp_addr = exp_q.pop_front();
        check_value(pc, exp_addr, "delivered pc");
        check_value(inst, expected_inst(exp_addr), "delivered inst");
        delivered++;
        taken = 1'b1;
      end else if (inst_valid) begin
        held = 1'b1;
        held_pc = pc;
        held_inst = inst;
      end
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout: the fetch stage stopped delivering instructions");
    stop_run();
  end

  initial begin
    inst_t word;
    rst             = 1'b1;
    pc_sel          = PC_SEL_SEQ;
    jump_reg_target = '0;
    br_target       = '0;
    jmp_target      = '0;
    pc_wen          = 1'b0;
    inst_ready      = 1'b0;
    load_en         = 1'b0;
    load_addr       = '0;
    load_data       = '0;

    // Program load without ebreak while reset is held
    for (int i = 0; i < IMEM_DEPTH; i++) begin
      word = $random(seed);
      if (word == EBREAK_INST)
        word = ~word;
      mem_copy[i] = word;
      @(posedge clk);
      load_en   <= 1'b1;
      load_addr <= addr_t'(i) << 2;
      load_data <= word;
    end
    @(posedge clk);
    load_en <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    exp_pc = RESET_PC;
    exp_q.push_back(exp_pc);
    rst <= 1'b0;

    // First fetch after reset
    accept_inst(0, 1'b0);

    // Sequential run across the memory wrap
    for (int i = 0; i < SEQ_FETCHES; i++) begin
      issue_fetch(PC_SEL_SEQ, rand_target(), rand_target(), rand_target());
      accept_inst(0, 1'b0);
    end

    // Redirects with all select codes
    for (int i = 0; i < RAND_FETCHES; i++) begin
      issue_fetch(pc_sel_t'($random(seed)), rand_target(), rand_target(), rand_target());
      accept_inst(0, 1'b0);
    end

    for (int i = 0; i < BP_FETCHES; i++) begin
      issue_fetch(pc_sel_t'($random(seed)), rand_target(), rand_target(), rand_target());
      accept_inst($random(seed) & 32'h7, 1'b0);
    end

    // Stray pc_wen pulses while a fetch is running
    for (int i = 0; i < NOISE_FETCHES; i++) begin
      issue_fetch(pc_sel_t'($random(seed)), rand_target(), rand_target(), rand_target());
      accept_inst($random(seed) & 32'h3, 1'b1);
    end

    check_value(halt, 1'b0, "halt before ebreak");
    load_en   <= 1'b1;
    load_addr <= HALT_ADDR;
    load_data <= EBREAK_INST;
    mem_copy[(HALT_ADDR >> 2) % IMEM_DEPTH] = EBREAK_INST;
    @(posedge clk);
    load_en <= 1'b0;
    issue_fetch(PC_SEL_JMP, rand_target(), rand_target(), HALT_ADDR);
    accept_inst(0, 1'b0);
    @(posedge clk);
    check_value(halt, 1'b1, "halt after ebreak");
    for (int i = 1; i < HALT_FETCHES; i++) begin
      issue_fetch(PC_SEL_SEQ, rand_target(), rand_target(), rand_target());
      accept_inst(0, 1'b0);
      check_value(halt, 1'b1, "halt on later fetches");
    end

    @(posedge clk);
    check_value(exp_q.size(), 0, "fetches left undelivered");
    check_value(delivered, TOTAL_FETCHES, "delivered instruction count");
    $display("all tests passed");
    $finish;
  end

endmodule

//--- inst_fetch_top.f
hdl/fetch_pkg.sv
hdl/axil_read_if.sv
hdl/inst_fetch.sv
hdl/imem_axil.sv
hdl/inst_fetch_top.sv
dv/inst_fetch_checker.sv
dv/inst_fetch_tb.sv
